// ==== rtl/execPkg.sv ====
package execPkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // Operation codes follow the ALUop encoding of the integer core
   typedef enum logic [3:0] {
      OP_AND     = 4'd0,
      OP_OR      = 4'd1,
      OP_ADD     = 4'd2,
      OP_XOR     = 4'd3,
      OP_SLL     = 4'd4,
      OP_SRL     = 4'd5,
      OP_SUB     = 4'd6,
      OP_SRA     = 4'd7,
      OP_SLT     = 4'd8,
      OP_SLTU    = 4'd9,
      OP_BTARGET = 4'd10,  // A + 4 + B
      OP_LUI     = 4'd11   // Passes B
   } aluOpT;

   typedef enum logic [1:0] {
      FWD_REG = 2'd0,  // Register file value
      FWD_WB  = 2'd1,  // From MEM/WB
      FWD_MEM = 2'd2   // From EX/MEM
   } fwdSelT;

   typedef struct packed {
      logic usePc;   // A takes PC
      logic useImm;  // B takes immediate
   } srcSelT;

   typedef struct packed {
      logic negative;
      logic zero;
      logic overflow;  // ADD and SUB only
      logic carry;     // Carry out or borrow
   } aluFlagsT;

   // Decoded instruction as it enters ID/EX
   typedef struct packed {
      aluOpT                 op;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       imm;
      logic [XLEN-1:0]       pc;
      srcSelT                src;
   } issueT;

   // Payload of EX/MEM and MEM/WB
   typedef struct packed {
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       value;
      aluFlagsT              flags;
   } resultT;

endpackage

// ==== rtl/pipeReg.sv ====
module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    inValid,
   input  payloadT inData,
   output logic    outValid,
   output payloadT outData
);

   always_ff @(posedge clk) begin
      if (rst) begin
         outValid <= 1'b0;
      end else begin
         outValid <= inValid;
      end
   end

   always_ff @(posedge clk) begin
      if (inValid) begin
         outData <= inData;  // Holds last payload through bubbles
      end
   end

   // Valid chain must stay clean once reset has gone through
   assertValidKnown: assert property (
      @(posedge clk) disable iff (rst) !$isunknown(outValid)
   ) else $error("pipeReg valid bit unknown");

endmodule

// ==== rtl/regFile.sv ====
module regFile (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [execPkg::REG_ADDR_W-1:0]   rdAddrA,
   input  logic [execPkg::REG_ADDR_W-1:0]   rdAddrB,
   output logic [execPkg::XLEN-1:0]         rdDataA,
   output logic [execPkg::XLEN-1:0]         rdDataB,
   input  logic                             wrEn,
   input  execPkg::resultT                  wrData
);

   logic [execPkg::XLEN-1:0] regs [1:31];  // x0 has no storage
   logic                     wrHit;

   assign wrHit = wrEn && (wrData.rd != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrHit) begin
         regs[wrData.rd] <= wrData.value;
      end
   end

   // Write lands at the edge, so a read in the next cycle already sees it
   assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
   assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

   // A retiring result must carry a known destination and value
   assertWriteKnown: assert property (
      @(posedge clk) disable iff (rst) wrEn |-> !$isunknown(wrData)
   ) else $error("register write with unknown destination or value");

endmodule

// ==== rtl/forwardUnit.sv ====
module forwardUnit (
   input  logic [execPkg::REG_ADDR_W-1:0] rs1,
   input  logic [execPkg::REG_ADDR_W-1:0] rs2,
   input  logic                           exMemValid,
   input  execPkg::resultT                exMem,
   input  logic                           memWbValid,
   input  execPkg::resultT                memWb,
   output execPkg::fwdSelT                selA,
   output execPkg::fwdSelT                selB
);

   // Newest producer wins, so EX/MEM is checked before MEM/WB
   function automatic execPkg::fwdSelT pickSrc(
      input logic [execPkg::REG_ADDR_W-1:0] rs,
      input logic                           memValid,
      input logic [execPkg::REG_ADDR_W-1:0] memRd,
      input logic                           wbValid,
      input logic [execPkg::REG_ADDR_W-1:0] wbRd
   );
      if (memValid && (memRd != '0) && (memRd == rs)) begin
         return execPkg::FWD_MEM;
      end else if (wbValid && (wbRd != '0) && (wbRd == rs)) begin
         return execPkg::FWD_WB;
      end
      return execPkg::FWD_REG;
   endfunction

   assign selA = pickSrc(rs1, exMemValid, exMem.rd, memWbValid, memWb.rd);
   assign selB = pickSrc(rs2, exMemValid, exMem.rd, memWbValid, memWb.rd);

endmodule

// ==== rtl/aluCore.sv ====
module aluCore (
   input  logic [execPkg::XLEN-1:0] a,
   input  logic [execPkg::XLEN-1:0] b,
   input  execPkg::aluOpT           op,
   output logic [execPkg::XLEN-1:0] result,
   output execPkg::aluFlagsT        flags
);

   logic [execPkg::XLEN:0]   addFull;  // Top bit is carry out
   logic [execPkg::XLEN-1:0] subDiff;
   logic [4:0]               shamt;
   logic                     signA;
   logic                     signB;
   logic                     signR;

   assign addFull = {1'b0, a} + {1'b0, b};
   assign subDiff = a - b;
   assign shamt   = b[4:0];  // RV32I uses low five bits
   assign signA   = a[execPkg::XLEN-1];
   assign signB   = b[execPkg::XLEN-1];
   assign signR   = result[execPkg::XLEN-1];

   always_comb begin
      case (op)
         execPkg::OP_AND: begin
            result = a & b;
         end
         execPkg::OP_OR: begin
            result = a | b;
         end
         execPkg::OP_ADD: begin
            result = addFull[execPkg::XLEN-1:0];
         end
         execPkg::OP_XOR: begin
            result = a ^ b;
         end
         execPkg::OP_SLL: begin
            result = a << shamt;
         end
         execPkg::OP_SRL: begin
            result = a >> shamt;
         end
         execPkg::OP_SUB: begin
            result = subDiff;
         end
         execPkg::OP_SRA: begin
            result = $signed(a) >>> shamt;  // Sign bit fills from the left
         end
         execPkg::OP_SLT: begin
            result = {{(execPkg::XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
         end
         execPkg::OP_SLTU: begin
            result = {{(execPkg::XLEN-1){1'b0}}, (a < b)};
         end
         execPkg::OP_BTARGET: begin
            result = a + b + 4;
         end
         execPkg::OP_LUI: begin
            result = b;  // Immediate already shifted by decode
         end
         default: begin
            result = '0;  // Unused codes
         end
      endcase
   end

   // Overflow and carry carry meaning only for ADD and SUB
   always_comb begin
      flags          = '0;
      flags.negative = signR;
      flags.zero     = (result == '0);
      if (op == execPkg::OP_ADD) begin
         flags.carry    = addFull[execPkg::XLEN];
         flags.overflow = (signA == signB) && (signR != signA);
      end else if (op == execPkg::OP_SUB) begin
         flags.carry    = (a < b);  // Unsigned borrow
         flags.overflow = (signA != signB) && (signR != signA);
      end
   end

endmodule

// ==== rtl/executeStage.sv ====
module executeStage (
   input  logic                     issueValid,
   input  execPkg::issueT           issue,
   input  logic [execPkg::XLEN-1:0] regA,
   input  logic [execPkg::XLEN-1:0] regB,
   input  logic                     exMemValid,
   input  execPkg::resultT          exMem,
   input  logic                     memWbValid,
   input  execPkg::resultT          memWb,
   output execPkg::resultT          res
);

   execPkg::fwdSelT          selA;
   execPkg::fwdSelT          selB;
   logic [execPkg::XLEN-1:0] fwdA;
   logic [execPkg::XLEN-1:0] fwdB;
   logic [execPkg::XLEN-1:0] srcA;
   logic [execPkg::XLEN-1:0] srcB;
   logic [execPkg::XLEN-1:0] aluResult;
   execPkg::aluFlagsT        aluFlags;

   // Three-way operand pick, same order as the fwdSelT codes
   function automatic logic [execPkg::XLEN-1:0] fwdMux(
      input execPkg::fwdSelT          sel,
      input logic [execPkg::XLEN-1:0] regVal,
      input logic [execPkg::XLEN-1:0] wbVal,
      input logic [execPkg::XLEN-1:0] memVal
   );
      case (sel)
         execPkg::FWD_WB:  return wbVal;
         execPkg::FWD_MEM: return memVal;
         default:          return regVal;
      endcase
   endfunction

   forwardUnit forwardUnit_inst (
      .rs1        (issue.rs1),
      .rs2        (issue.rs2),
      .exMemValid (exMemValid),
      .exMem      (exMem),
      .memWbValid (memWbValid),
      .memWb      (memWb),
      .selA       (selA),
      .selB       (selB)
   );

   assign fwdA = fwdMux(selA, regA, memWb.value, exMem.value);
   assign fwdB = fwdMux(selB, regB, memWb.value, exMem.value);

   // Source selects apply after forwarding
   assign srcA = issue.src.usePc  ? issue.pc  : fwdA;
   assign srcB = issue.src.useImm ? issue.imm : fwdB;

   aluCore aluCore_inst (
      .a      (srcA),
      .b      (srcB),
      .op     (issue.op),
      .result (aluResult),
      .flags  (aluFlags)
   );

   assign res.rd    = issueValid ? issue.rd : '0;  // Bubble has no destination
   assign res.value = aluResult;
   assign res.flags = aluFlags;

endmodule

// ==== rtl/execPipeTop.sv ====
module execPipeTop (
   input  logic            clk,
   input  logic            rst,
   input  logic            issueValid,
   input  execPkg::issueT  issue,
   output logic            wbValid,
   output execPkg::resultT wb
);

   logic                     idExValid;
   execPkg::issueT           idEx;
   logic [execPkg::XLEN-1:0] regA;
   logic [execPkg::XLEN-1:0] regB;
   execPkg::resultT          exRes;
   logic                     exMemValid;
   execPkg::resultT          exMem;

   pipeReg #(
      .payloadT (execPkg::issueT)
   ) idExReg (
      .clk      (clk),
      .rst      (rst),
      .inValid  (issueValid),
      .inData   (issue),
      .outValid (idExValid),
      .outData  (idEx)
   );

   // Written from MEM/WB, read by the instruction in ID/EX
   regFile regFile_inst (
      .clk     (clk),
      .rst     (rst),
      .rdAddrA (idEx.rs1),
      .rdAddrB (idEx.rs2),
      .rdDataA (regA),
      .rdDataB (regB),
      .wrEn    (wbValid),
      .wrData  (wb)
   );

   executeStage executeStage_inst (
      .issueValid (idExValid),
      .issue      (idEx),
      .regA       (regA),
      .regB       (regB),
      .exMemValid (exMemValid),
      .exMem      (exMem),
      .memWbValid (wbValid),
      .memWb      (wb),
      .res        (exRes)
   );

   pipeReg #(
      .payloadT (execPkg::resultT)
   ) exMemReg (
      .clk      (clk),
      .rst      (rst),
      .inValid  (idExValid),
      .inData   (exRes),
      .outValid (exMemValid),
      .outData  (exMem)
   );

   // No load path, MEM slot only carries the result along
   pipeReg #(
      .payloadT (execPkg::resultT)
   ) memWbReg (
      .clk      (clk),
      .rst      (rst),
      .inValid  (exMemValid),
      .inData   (exMem),
      .outValid (wbValid),
      .outData  (wb)
   );

endmodule

// ==== testbench/execPipeTb.sv ====
module execPipeTb;

   localparam int          CLK_PERIOD = 20;
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
   localparam int          DRAIN_MAX  = 50;

   logic            clk;
   logic            rst;
   logic            issueValid;
   execPkg::issueT  issue;
   logic            wbValid;
   execPkg::resultT wb;

   logic [31:0]     modelRegs [32];  // In-order architectural state
   execPkg::resultT expQ [$];
   execPkg::resultT monExp;
   logic [31:0]     lfsrState;
   string           curTest;
   int              issueCount;
   int              passCount;
   int              errorCount;
   int              testErrStart;
   int              wdCycles;

   execPipeTop execPipeTop_inst (
      .clk        (clk),
      .rst        (rst),
      .issueValid (issueValid),
      .issue      (issue),
      .wbValid    (wbValid),
      .wb         (wb)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic compareValues(input string what, input logic [63:0] expVal,
                                input logic [63:0] actVal);
      if (expVal !== actVal) begin
         errorCount++;
         $display("ERROR %s %s: expected %h, actual %h", curTest, what, expVal, actVal);
      end else begin
         passCount++;
      end
   endtask

   // Galois LFSR, one step per bit
   function automatic logic [31:0] nextRandom(input int nBits);
      logic        outBit;
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < nBits; i++) begin
         outBit    = lfsrState[0];
         lfsrState = (lfsrState >> 1) ^ (outBit ? LFSR_TAPS : 32'h0);
         val       = {val[30:0], outBit};
      end
      return val;
   endfunction

   function automatic execPkg::resultT aluModel(input execPkg::aluOpT op,
                                                input logic [31:0] a, input logic [31:0] b);
      execPkg::resultT r;
      logic [32:0]     wide;
      logic [63:0]     ext;
      logic [4:0]      sh;
      r  = '0;
      sh = b[4:0];
      case (op)
         execPkg::OP_AND:     r.value = a & b;
         execPkg::OP_OR:      r.value = a | b;
         execPkg::OP_ADD:     r.value = a + b;
         execPkg::OP_XOR:     r.value = a ^ b;
         execPkg::OP_SLL:     r.value = a << sh;
         execPkg::OP_SRL:     r.value = a >> sh;
         execPkg::OP_SUB:     r.value = a - b;
         execPkg::OP_SRA: begin
            ext     = {{32{a[31]}}, a} >> sh;  // Sign-extended then logical shift
            r.value = ext[31:0];
         end
         execPkg::OP_SLT:     r.value = {31'd0, ((a ^ 32'h80000000) < (b ^ 32'h80000000))};
         execPkg::OP_SLTU:    r.value = {31'd0, (a < b)};
         execPkg::OP_BTARGET: r.value = a + 32'd4 + b;
         execPkg::OP_LUI:     r.value = b;
         default:             r.value = '0;
      endcase
      r.flags.negative = r.value[31];
      r.flags.zero     = (r.value == 32'd0);
      if (op == execPkg::OP_ADD) begin
         wide             = {1'b0, a} + {1'b0, b};
         r.flags.carry    = wide[32];
         r.flags.overflow = (a[31] == b[31]) && (r.value[31] != a[31]);
      end else if (op == execPkg::OP_SUB) begin
         wide             = {1'b0, a} - {1'b0, b};  // Bit 32 set on borrow
         r.flags.carry    = wide[32];
         r.flags.overflow = (a[31] != b[31]) && (r.value[31] != a[31]);
      end
      return r;
   endfunction

   task automatic issueOne(input execPkg::aluOpT op, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [4:0] rd,
                           input logic [31:0] imm, input logic [31:0] pc,
                           input logic usePc, input logic useImm);
      execPkg::issueT  ins;
      execPkg::resultT expRes;
      logic [31:0]     opA;
      logic [31:0]     opB;
      ins.op         = op;
      ins.rs1        = rs1;
      ins.rs2        = rs2;
      ins.rd         = rd;
      ins.imm        = imm;
      ins.pc         = pc;
      ins.src.usePc  = usePc;
      ins.src.useImm = useImm;
      opA            = usePc ? pc : modelRegs[rs1];
      opB            = useImm ? imm : modelRegs[rs2];
      expRes         = aluModel(op, opA, opB);
      expRes.rd      = rd;
      if (rd != 5'd0) begin
         modelRegs[rd] = expRes.value;
      end
      expQ.push_back(expRes);
      issueCount++;
      @(posedge clk);
      issueValid <= 1'b1;
      issue      <= ins;
   endtask

   task automatic immOp(input execPkg::aluOpT op, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [31:0] imm);
      issueOne(op, rs1, 5'd0, rd, imm, 32'd0, 1'b0, 1'b1);
   endtask

   task automatic regOp(input execPkg::aluOpT op, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
      issueOne(op, rs1, rs2, rd, 32'd0, 32'd0, 1'b0, 1'b0);
   endtask

   task automatic loadReg(input logic [4:0] rd, input logic [31:0] val);
      immOp(execPkg::OP_LUI, rd, 5'd0, {val[31:12], 12'h000});
      immOp(execPkg::OP_ADD, rd, rd, {20'h0, val[11:0]});
   endtask

   task automatic beginTest(input string name);
      curTest      = name;
      testErrStart = errorCount;
   endtask

   task automatic endTest();
      int waited;
      waited = 0;
      @(posedge clk);
      issueValid <= 1'b0;
      while (expQ.size() != 0 && waited < DRAIN_MAX) begin
         @(posedge clk);
         waited++;
      end
      if (expQ.size() != 0) begin
         errorCount++;
         $display("%s: %0d writebacks never arrived", curTest, expQ.size());
         expQ.delete();
      end
      $display("Test %s finished with %0d errors", curTest, errorCount - testErrStart);
   endtask

   // Writeback monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (!rst && wbValid) begin
         if (expQ.size() == 0) begin
            errorCount++;
            $display("%s: writeback seen with no instruction outstanding", curTest);
         end else begin
            monExp = expQ.pop_front();
            compareValues("wb", monExp, wb);
         end
      end
   end

   task automatic resetAndIdle();
      beginTest("resetIdle");
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         compareValues("wbValid idle", 64'd0, {63'd0, wbValid});
      end
      for (int r = 0; r < 32; r++) begin
         regOp(execPkg::OP_ADD, 5'd0, 5'(r), 5'd0);  // Port A read
         regOp(execPkg::OP_OR, 5'd0, 5'd0, 5'(r));   // Port B read
      end
      endTest();
   endtask

   task automatic aluOperations();
      logic [31:0] valA;
      logic [31:0] valB;
      logic [31:0] valN;
      beginTest("operations");
      valA     = nextRandom(32);
      valB     = nextRandom(32);
      valN     = nextRandom(31);
      valN[31] = 1'b1;  // Negative for SRA
      loadReg(5'd1, valA);
      loadReg(5'd2, valB);
      loadReg(5'd3, valN);
      for (int op = 0; op < 13; op++) begin
         regOp(execPkg::aluOpT'(4'(op)), 5'(op + 4), 5'd1, 5'd2);  // Code 12 is unused
      end
      immOp(execPkg::OP_SLL, 5'd20, 5'd3, 32'd0);
      immOp(execPkg::OP_SLL, 5'd21, 5'd3, 32'd31);
      immOp(execPkg::OP_SRL, 5'd22, 5'd3, 32'd0);
      immOp(execPkg::OP_SRL, 5'd23, 5'd3, 32'd31);
      immOp(execPkg::OP_SRA, 5'd24, 5'd3, 32'd0);
      immOp(execPkg::OP_SRA, 5'd25, 5'd3, 32'd31);
      regOp(execPkg::OP_SLT, 5'd26, 5'd3, 5'd1);
      regOp(execPkg::OP_SLTU, 5'd27, 5'd3, 5'd1);
      endTest();
   endtask

   task automatic flagCorners();
      beginTest("flagCorners");
      loadReg(5'd10, 32'h7fffffff);
      loadReg(5'd11, 32'hffffffff);
      loadReg(5'd12, 32'h80000000);
      loadReg(5'd13, 32'h00000001);
      regOp(execPkg::OP_ADD, 5'd20, 5'd10, 5'd13);  // Signed overflow
      regOp(execPkg::OP_ADD, 5'd21, 5'd11, 5'd13);  // Carry, zero
      regOp(execPkg::OP_ADD, 5'd22, 5'd12, 5'd12);  // Carry and overflow
      regOp(execPkg::OP_ADD, 5'd23, 5'd11, 5'd11);
      regOp(execPkg::OP_SUB, 5'd24, 5'd12, 5'd13);  // Signed overflow
      regOp(execPkg::OP_SUB, 5'd25, 5'd0, 5'd13);   // Borrow
      regOp(execPkg::OP_SUB, 5'd26, 5'd10, 5'd11);  // Overflow and borrow
      regOp(execPkg::OP_SUB, 5'd27, 5'd13, 5'd13);
      regOp(execPkg::OP_XOR, 5'd28, 5'd11, 5'd13);  // No arithmetic flags
      regOp(execPkg::OP_SLTU, 5'd29, 5'd13, 5'd11);
      endTest();
   endtask

   task automatic forwardingPaths();
      logic [31:0]     rnd;
      execPkg::aluOpT  op;
      beginTest("forwarding");
      immOp(execPkg::OP_ADD, 5'd1, 5'd0, 32'd5);
      immOp(execPkg::OP_ADD, 5'd2, 5'd1, 32'd3);    // Distance 1
      immOp(execPkg::OP_ADD, 5'd3, 5'd0, 32'd7);
      immOp(execPkg::OP_OR, 5'd20, 5'd0, 32'hf0);
      regOp(execPkg::OP_SUB, 5'd4, 5'd3, 5'd1);     // Distance 2
      immOp(execPkg::OP_ADD, 5'd5, 5'd0, 32'd9);
      immOp(execPkg::OP_OR, 5'd21, 5'd0, 32'h1);
      immOp(execPkg::OP_OR, 5'd22, 5'd0, 32'h2);
      immOp(execPkg::OP_ADD, 5'd6, 5'd5, 32'd1);    // Distance 3 via regFile
      immOp(execPkg::OP_ADD, 5'd7, 5'd0, 32'd11);
      regOp(execPkg::OP_ADD, 5'd8, 5'd7, 5'd7);     // Both operands
      immOp(execPkg::OP_ADD, 5'd9, 5'd0, 32'd1);
      immOp(execPkg::OP_ADD, 5'd9, 5'd0, 32'd2);
      regOp(execPkg::OP_ADD, 5'd10, 5'd9, 5'd0);    // Newest write must win
      for (int i = 0; i < 16; i++) begin
         rnd = nextRandom(8);
         case (rnd[1:0])
            2'd0: op = execPkg::OP_ADD;
            2'd1: op = execPkg::OP_SUB;
            2'd2: op = execPkg::OP_XOR;
            default: op = execPkg::OP_SLL;
         endcase
         regOp(op, {3'd0, rnd[3:2]} + 5'd1, {3'd0, rnd[5:4]} + 5'd1,
               {3'd0, rnd[7:6]} + 5'd1);
      end
      endTest();
   endtask

   task automatic zeroRegister();
      beginTest("regZero");
      immOp(execPkg::OP_ADD, 5'd0, 5'd0, 32'h55);   // Visible on wb only
      regOp(execPkg::OP_ADD, 5'd1, 5'd0, 5'd0);
      immOp(execPkg::OP_ADD, 5'd0, 5'd0, 32'h66);
      immOp(execPkg::OP_XOR, 5'd2, 5'd2, 32'h1);
      regOp(execPkg::OP_OR, 5'd3, 5'd0, 5'd0);
      immOp(execPkg::OP_LUI, 5'd0, 5'd0, 32'hfffff000);
      immOp(execPkg::OP_ADD, 5'd0, 5'd0, 32'h7);
      regOp(execPkg::OP_SUB, 5'd4, 5'd0, 5'd0);
      endTest();
   endtask

   task automatic sourceSelects();
      logic [31:0] pcVal;
      beginTest("sourceSelects");
      pcVal = nextRandom(32);
      loadReg(5'd5, 32'h00000100);
      issueOne(execPkg::OP_BTARGET, 5'd0, 5'd0, 5'd6, 32'h20, 32'h1000, 1'b1, 1'b1);
      issueOne(execPkg::OP_BTARGET, 5'd0, 5'd5, 5'd7, 32'd0, 32'h2000, 1'b1, 1'b0);
      issueOne(execPkg::OP_ADD, 5'd5, 5'd5, 5'd8, 32'd0, pcVal, 1'b1, 1'b0);
      issueOne(execPkg::OP_LUI, 5'd9, 5'd0, 5'd9, 32'hdeadb000, 32'd0, 1'b0, 1'b1);
      issueOne(execPkg::OP_SUB, 5'd9, 5'd9, 5'd10, 32'h1000, 32'h4000, 1'b0, 1'b1);
      issueOne(execPkg::OP_ADD, 5'd0, 5'd10, 5'd11, 32'd0, pcVal, 1'b1, 1'b0);
      endTest();
   endtask

   // Budget grows with the number of issued instructions
   initial begin
      wdCycles = 0;
      while (wdCycles <= 40 * issueCount + 200) begin
         @(posedge clk);
         wdCycles++;
      end
      $display("Timeout: the run took longer than its cycle budget");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      rst        = 1'b1;
      issueValid = 1'b0;
      issue      = '0;
      lfsrState  = 32'h271f;
      issueCount = 0;
      passCount  = 0;
      errorCount = 0;
      curTest    = "reset";
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = '0;
      end
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      resetAndIdle();
      aluOperations();
      flagCorners();
      forwardingPaths();
      zeroRegister();
      sourceSelects();
      $display("Checks passed: %0d, failures: %0d", passCount, errorCount);
      if (errorCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== list.f ====
rtl/execPkg.sv
rtl/pipeReg.sv
rtl/regFile.sv
rtl/forwardUnit.sv
rtl/aluCore.sv
rtl/executeStage.sv
rtl/execPipeTop.sv
testbench/execPipeTb.sv

// ==== Bender.yml ====
package:
  name: execPipe

sources:
  - rtl/execPkg.sv
  - rtl/pipeReg.sv
  - rtl/regFile.sv
  - rtl/forwardUnit.sv
  - rtl/aluCore.sv
  - rtl/executeStage.sv
  - rtl/execPipeTop.sv
  - target: test
    files:
      - testbench/execPipeTb.sv
